// ==== hw/isa_pkg.sv ====
package isa_pkg;

	// Major opcode field, instruction bits 6:0
	typedef enum logic [6:0] {
		op_other  = 7'b0000000,
		op_branch = 7'b1100011,
		op_jalr   = 7'b1100111,
		op_jal    = 7'b1101111,
		op_system = 7'b1110011
	} opcode_t;

	// What fetch has to do after delivering the instruction
	typedef enum logic [1:0] {
		class_sequential,
		class_jump,
		class_trap
	} instr_class_t;

	// Exact system encodings, all register fields zero
	localparam logic [31:0] ecall_word = 32'h0000_0073;
	localparam logic [31:0] mret_word = 32'h3020_0073;
	localparam logic [31:0] wfi_word = 32'h1050_0073;

endpackage

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

	// Byte address; instructions are word aligned
	localparam int addr_width = 32;

	localparam int instr_width = 32;

	// Record tag, wraps around
	localparam int tag_width = 8;

	// Fetch FSM states
	typedef enum logic [1:0] {
		wait_icache,
		wait_jump,
		wait_irq
	} fetch_state_t;

endpackage

// ==== hw/icache_line.sv ====
`timescale 1ns/1ps

module icache_line #(
	parameter int icache_lines = 8,
	parameter int line_index = 0
) (
	input logic i_clock,
	input logic i_reset,
	input logic [fetch_pkg::addr_width-1:0] i_pc,
	input logic i_fill,
	input logic [fetch_pkg::addr_width-1:0] i_fill_pc,
	input logic [fetch_pkg::instr_width-1:0] i_fill_word,
	output logic o_hit,
	output logic [fetch_pkg::instr_width-1:0] o_word
);
	import fetch_pkg::*;

	localparam int index_width = $clog2(icache_lines);
	localparam int line_tag_width = addr_width - index_width - 2;
	localparam logic [index_width-1:0] own_index = index_width'(line_index);

	logic valid;
	logic [line_tag_width-1:0] tag;
	logic [instr_width-1:0] word;
	logic fill_here;

	// Refill writes only the line its index selects
	assign fill_here = i_fill && (i_fill_pc[index_width+1:2] == own_index);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			valid <= 1'b0;
		end else if (fill_here) begin
			valid <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (fill_here) begin
			tag <= i_fill_pc[addr_width-1:index_width+2];
			word <= i_fill_word;
		end
	end

	assign o_hit = valid && (i_pc[index_width+1:2] == own_index)
		&& (i_pc[addr_width-1:index_width+2] == tag);

	// Zero when not hitting so the cache can OR all lines together
	assign o_word = o_hit ? word : '0;

endmodule

// ==== hw/icache_refill.sv ====
`timescale 1ns/1ps

module icache_refill #(
	parameter int icache_lines = 8
) (
	input logic i_clock,
	input logic i_reset,
	input logic [fetch_pkg::addr_width-1:0] i_pc,
	input logic i_miss,
	output logic o_bus_request,
	output logic [fetch_pkg::addr_width-1:0] o_bus_address,
	input logic i_bus_ready,
	input logic [fetch_pkg::instr_width-1:0] i_bus_rdata,
	output logic o_fill,
	output logic [fetch_pkg::addr_width-1:0] o_fill_pc,
	output logic [fetch_pkg::instr_width-1:0] o_fill_word
);
	import fetch_pkg::*;

	typedef enum logic {
		refill_idle,
		refill_busy
	} refill_state_t;

	refill_state_t state;
	logic [addr_width-1:0] miss_pc;

	// Lines split the pc into index and tag, so the count must be a power of two
	if (icache_lines < 2 || (icache_lines & (icache_lines - 1)) != 0) begin : g_lines_check
		$error("icache_lines must be a power of two, at least 2");
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= refill_idle;
		end else begin
			case (state)
				refill_idle: begin
					if (i_miss) begin
						state <= refill_busy;
					end
				end
				refill_busy: begin
					if (i_bus_ready) begin
						state <= refill_idle;
					end
				end
				default: begin
					state <= refill_idle;
				end
			endcase
		end
	end

	// Word aligned address of the miss, held for the whole request
	always_ff @(posedge i_clock) begin
		if (state == refill_idle && i_miss) begin
			miss_pc <= {i_pc[addr_width-1:2], 2'b00};
		end
	end

	assign o_bus_request = (state == refill_busy);
	assign o_bus_address = miss_pc;

	// Write goes straight in on the ready cycle, hit follows next cycle
	assign o_fill = (state == refill_busy) && i_bus_ready;
	assign o_fill_pc = miss_pc;
	assign o_fill_word = i_bus_rdata;

	a_address_stable: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request && $stable(o_bus_address));

endmodule

// ==== hw/icache.sv ====
`timescale 1ns/1ps

module icache #(
	parameter int icache_lines = 8
) (
	input logic i_clock,
	input logic i_reset,
	input logic [fetch_pkg::addr_width-1:0] i_pc,
	input logic i_lookup,
	output logic o_ready,
	output logic [fetch_pkg::instr_width-1:0] o_rdata,
	output logic o_bus_request,
	output logic [fetch_pkg::addr_width-1:0] o_bus_address,
	input logic i_bus_ready,
	input logic [fetch_pkg::instr_width-1:0] i_bus_rdata
);
	import fetch_pkg::*;

	logic [icache_lines-1:0] line_hits;
	logic [instr_width-1:0] line_words [icache_lines];
	logic any_hit;
	logic miss;
	logic fill;
	logic [addr_width-1:0] fill_pc;
	logic [instr_width-1:0] fill_word;

	icache_refill #(
		.icache_lines(icache_lines)
	) refill_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(i_pc),
		.i_miss(miss),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.o_fill(fill),
		.o_fill_pc(fill_pc),
		.o_fill_word(fill_word)
	);

	for (genvar i = 0; i < icache_lines; i++) begin : g_lines
		icache_line #(
			.icache_lines(icache_lines),
			.line_index(i)
		) line_i (
			.i_clock(i_clock),
			.i_reset(i_reset),
			.i_pc(i_pc),
			.i_fill(fill),
			.i_fill_pc(fill_pc),
			.i_fill_word(fill_word),
			.o_hit(line_hits[i]),
			.o_word(line_words[i])
		);
	end

	// Non-hitting lines output zero, so OR gives the hit word
	always_comb begin
		o_rdata = '0;
		for (int i = 0; i < icache_lines; i++) begin
			o_rdata = o_rdata | line_words[i];
		end
	end

	assign any_hit = |line_hits;
	assign o_ready = i_lookup && any_hit;
	assign miss = i_lookup && !any_hit;

	a_one_hit: assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot0(line_hits));

endmodule

// ==== hw/instr_classify.sv ====
`timescale 1ns/1ps

module instr_classify (
	input logic [fetch_pkg::instr_width-1:0] i_instruction,
	output isa_pkg::instr_class_t o_class
);
	import isa_pkg::*;

	opcode_t opcode;

	always_comb begin
		case (i_instruction[6:0])
			op_jal: opcode = op_jal;
			op_jalr: opcode = op_jalr;
			op_branch: opcode = op_branch;
			op_system: opcode = op_system;
			default: opcode = op_other;
		endcase
	end

	// CSR accesses share the system opcode and stay sequential
	always_comb begin
		case (opcode)
			op_jal, op_jalr, op_branch: begin
				o_class = class_jump;
			end
			op_system: begin
				if (i_instruction == mret_word) begin
					o_class = class_jump;
				end else if (i_instruction == ecall_word || i_instruction == wfi_word) begin
					o_class = class_trap;
				end else begin
					o_class = class_sequential;
				end
			end
			default: begin
				o_class = class_sequential;
			end
		endcase
	end

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
	parameter logic [fetch_pkg::addr_width-1:0] reset_vector = '0
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_busy,

	// Redirect after a control-flow instruction
	input logic i_jump,
	input logic [fetch_pkg::addr_width-1:0] i_jump_pc,

	// Interrupt
	input logic i_irq_pending,
	input logic [fetch_pkg::addr_width-1:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [fetch_pkg::addr_width-1:0] o_irq_epc,

	// Cache side
	output logic [fetch_pkg::addr_width-1:0] o_pc,
	output logic o_lookup,
	input logic i_ready,
	input logic [fetch_pkg::instr_width-1:0] i_rdata,
	input isa_pkg::instr_class_t i_class,

	// Record to the next stage
	output logic [fetch_pkg::tag_width-1:0] o_fetch_tag,
	output logic [fetch_pkg::addr_width-1:0] o_fetch_pc,
	output logic [fetch_pkg::instr_width-1:0] o_fetch_instruction
);
	import isa_pkg::*;
	import fetch_pkg::*;

	fetch_state_t state;
	logic [addr_width-1:0] pc;
	logic last_pending;
	logic irq_edge;
	logic accept;
	logic take_seq_irq;
	logic take_trap_irq;

	assign o_pc = pc;
	assign o_lookup = (state == wait_icache) && !i_busy;
	assign accept = o_lookup && i_ready;
	assign irq_edge = i_irq_pending && !last_pending;

	// Interrupts only after an ordinary instruction or while parked on a trap
	assign take_seq_irq = accept && (i_class == class_sequential) && irq_edge;
	assign take_trap_irq = (state == wait_irq) && irq_edge;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= wait_icache;
			pc <= reset_vector;
			last_pending <= 1'b0;
			o_irq_dispatched <= 1'b0;
			o_fetch_tag <= '0;
		end else begin
			o_irq_dispatched <= 1'b0;
			case (state)
				wait_icache: begin
					if (accept) begin
						o_fetch_tag <= o_fetch_tag + tag_width'(1);
						pc <= pc + addr_width'(4);
						if (i_class == class_jump) begin
							state <= wait_jump;
						end else if (i_class == class_trap) begin
							state <= wait_irq;
						end else begin
							last_pending <= i_irq_pending;
							if (take_seq_irq) begin
								o_irq_dispatched <= 1'b1;
								pc <= i_irq_pc;
							end
						end
					end
				end
				wait_jump: begin
					// Hold until the next stage resolves the target
					if (i_jump) begin
						pc <= i_jump_pc;
						state <= wait_icache;
					end
				end
				wait_irq: begin
					last_pending <= i_irq_pending;
					if (take_trap_irq) begin
						o_irq_dispatched <= 1'b1;
						pc <= i_irq_pc;
						state <= wait_icache;
					end
				end
				default: begin
					state <= wait_icache;
				end
			endcase
		end
	end

	// Record and return address
	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_fetch_pc <= pc;
			o_fetch_instruction <= i_rdata;
		end
		if (take_seq_irq) begin
			o_irq_epc <= pc + addr_width'(4);
		end else if (take_trap_irq) begin
			// pc already points past the trap instruction
			o_irq_epc <= pc;
		end
	end

	a_state_legal: assert property (@(posedge i_clock) disable iff (i_reset)
		state inside {wait_icache, wait_jump, wait_irq});

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
	parameter logic [fetch_pkg::addr_width-1:0] reset_vector = 32'h0000_0000,
	parameter int icache_lines = 8
) (
	input logic i_clock,
	input logic i_reset,

	// Control
	input logic i_jump,
	input logic [fetch_pkg::addr_width-1:0] i_jump_pc,

	// Interrupt
	input logic i_irq_pending,
	input logic [fetch_pkg::addr_width-1:0] i_irq_pc,
	output logic o_irq_dispatched,
	output logic [fetch_pkg::addr_width-1:0] o_irq_epc,

	// Memory bus
	output logic o_bus_request,
	output logic [fetch_pkg::addr_width-1:0] o_bus_address,
	input logic i_bus_ready,
	input logic [fetch_pkg::instr_width-1:0] i_bus_rdata,

	// Record
	input logic i_busy,
	output logic [fetch_pkg::tag_width-1:0] o_fetch_tag,
	output logic [fetch_pkg::addr_width-1:0] o_fetch_pc,
	output logic [fetch_pkg::instr_width-1:0] o_fetch_instruction
);
	import isa_pkg::*;
	import fetch_pkg::*;

	logic [addr_width-1:0] pc;
	logic lookup;
	logic ready;
	logic [instr_width-1:0] rdata;
	instr_class_t instr_class;

	icache #(
		.icache_lines(icache_lines)
	) icache_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.i_lookup(lookup),
		.o_ready(ready),
		.o_rdata(rdata),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

	instr_classify instr_classify_i (
		.i_instruction(rdata),
		.o_class(instr_class)
	);

	fetch_unit #(
		.reset_vector(reset_vector)
	) fetch_unit_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_busy(i_busy),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_pc(pc),
		.o_lookup(lookup),
		.i_ready(ready),
		.i_rdata(rdata),
		.i_class(instr_class),
		.o_fetch_tag(o_fetch_tag),
		.o_fetch_pc(o_fetch_pc),
		.o_fetch_instruction(o_fetch_instruction)
	);

endmodule

// ==== tb/tb_bus_memory.sv ====
`timescale 1ns/1ps

module tb_bus_memory #(
	parameter int words = 1024,
	parameter int random_seed = 0
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_bus_request,
	input logic [31:0] i_bus_address,
	output logic o_bus_ready,
	output logic [31:0] o_bus_rdata,
	output int o_request_count
);
	localparam int index_width = $clog2(words);

	logic [31:0] mem [words];
	logic active;
	logic [1:0] delay;
	integer seed;

	// Filler mixes every address bit; OP-IMM opcode keeps it sequential
	function automatic logic [31:0] fill_word(input logic [31:0] address);
		logic [31:0] mixed;
		mixed = (address ^ (address >> 13)) * 32'h9E37_79B9;
		return {mixed[31:7], 7'b0010011};
	endfunction

	initial begin
		seed = random_seed;
		o_bus_ready <= 1'b0;
		o_bus_rdata <= '0;
		for (int i = 0; i < words; i++) begin
			mem[i] = fill_word(32'(i) << 2);
		end
	end

	// One request at a time, answered 0 to 3 cycles after it is seen
	always @(posedge i_clock) begin
		if (i_reset) begin
			active <= 1'b0;
			delay <= 2'd0;
			o_bus_ready <= 1'b0;
			o_bus_rdata <= '0;
			o_request_count <= 0;
		end else begin
			o_bus_ready <= 1'b0;
			if (active) begin
				if (delay == 2'd0) begin
					active <= 1'b0;
					o_bus_ready <= 1'b1;
					o_bus_rdata <= mem[i_bus_address[index_width+1:2]];
				end else begin
					delay <= delay - 2'd1;
				end
			end else if (i_bus_request && !o_bus_ready) begin
				active <= 1'b1;
				delay <= 2'($random(seed));
				o_request_count <= o_request_count + 1;
			end
		end
	end

endmodule

// ==== tb/tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top;
	import isa_pkg::*;

	localparam logic [31:0] reset_vector = 32'h0000_0100;
	localparam logic [31:0] handler_pc = 32'h0000_0300;
	localparam int icache_lines = 8;
	localparam int random_seed = 32'h0752_0518;
	// About 45 records, each at worst a full refill of 8 cycles, plus hold phases
	localparam int watchdog_ns = (45 * 8 + 300) * 10;

	logic i_clock;
	logic i_reset;
	logic i_busy;
	logic i_jump;
	logic [31:0] i_jump_pc;
	logic i_irq_pending;
	logic [31:0] i_irq_pc;
	logic o_irq_dispatched;
	logic [31:0] o_irq_epc;
	logic o_bus_request;
	logic [31:0] o_bus_address;
	logic i_bus_ready;
	logic [31:0] i_bus_rdata;
	logic [7:0] o_fetch_tag;
	logic [31:0] o_fetch_pc;
	logic [31:0] o_fetch_instruction;
	int request_count;
	int dispatch_count;
	int error_count;
	integer seed;
	logic [7:0] last_tag;

	fetch_top #(
		.reset_vector(reset_vector),
		.icache_lines(icache_lines)
	) fetch_top_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.i_busy(i_busy),
		.o_fetch_tag(o_fetch_tag),
		.o_fetch_pc(o_fetch_pc),
		.o_fetch_instruction(o_fetch_instruction)
	);

	tb_bus_memory #(
		.random_seed(random_seed)
	) memory_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_request(o_bus_request),
		.i_bus_address(o_bus_address),
		.o_bus_ready(i_bus_ready),
		.o_bus_rdata(i_bus_rdata),
		.o_request_count(request_count)
	);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	// Counts interrupt pulses a cycle late, read only at negedges
	always @(posedge i_clock) begin
		if (i_reset) begin
			dispatch_count <= 0;
		end else if (o_irq_dispatched) begin
			dispatch_count <= dispatch_count + 1;
		end
	end

	task automatic fail_run(input string what);
		error_count++;
		$display("%s", what);
		$display("Verification failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			error_count++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Verification failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic place_word(input logic [31:0] address, input logic [31:0] word);
		memory_i.mem[address[11:2]] = word;
	endtask

	task automatic load_program();
		// beq x0, x0, 0
		place_word(32'h0000_0118, 32'h0000_0063);
		place_word(32'h0000_0204, ecall_word);
		place_word(32'h0000_030C, mret_word);
		place_word(32'h0000_051C, 32'h0000_0063);
		// jal x0, 0 closes the reuse loop
		place_word(32'h0000_0610, 32'h0000_006F);
	endtask

	task automatic check_record(input logic [31:0] expected_pc);
		logic [7:0] expected_tag;
		expected_tag = last_tag + 8'd1;
		check_value("o_fetch_tag", 32'(o_fetch_tag), 32'(expected_tag));
		check_value("o_fetch_pc", o_fetch_pc, expected_pc);
		check_value("o_fetch_instruction", o_fetch_instruction,
			memory_i.mem[expected_pc[11:2]]);
		last_tag = o_fetch_tag;
	endtask

	task automatic next_record(input logic [31:0] expected_pc);
		int cycles;
		cycles = 0;
		@(negedge i_clock);
		while (o_fetch_tag == last_tag && cycles < 40) begin
			// Any refill while waiting must fetch the awaited word
			if (o_bus_request) begin
				check_value("o_bus_address", o_bus_address, expected_pc);
			end
			cycles++;
			@(negedge i_clock);
		end
		if (o_fetch_tag == last_tag) begin
			fail_run($sformatf("No record for pc %h arrived within 40 cycles", expected_pc));
		end else begin
			check_record(expected_pc);
		end
	endtask

	task automatic expect_no_record(input int cycles);
		repeat (cycles) begin
			@(negedge i_clock);
			check_value("o_fetch_tag", 32'(o_fetch_tag), 32'(last_tag));
		end
	endtask

	task automatic drive_jump(input logic [31:0] target);
		@(posedge i_clock);
		i_jump <= 1'b1;
		i_jump_pc <= target;
		@(posedge i_clock);
		i_jump <= 1'b0;
	endtask

	task automatic sequential_fetch();
		for (int i = 0; i < 6; i++) begin
			next_record(reset_vector + 32'(4 * i));
		end
	endtask

	task automatic jump_hold();
		next_record(reset_vector + 32'h18);
		expect_no_record(10);
		drive_jump(32'h0000_0200);
		next_record(32'h0000_0200);
	endtask

	task automatic trap_wait();
		int count_before;
		int cycles;
		next_record(32'h0000_0204);
		expect_no_record(8);
		count_before = dispatch_count;
		@(posedge i_clock);
		i_irq_pending <= 1'b1;
		cycles = 0;
		@(negedge i_clock);
		while (!o_irq_dispatched && cycles < 10) begin
			cycles++;
			@(negedge i_clock);
		end
		if (!o_irq_dispatched) begin
			fail_run("Interrupt edge during the trap wait was not dispatched");
		end else begin
			check_value("o_irq_epc", o_irq_epc, 32'h0000_0208);
		end
		// Level stays high through the handler
		next_record(handler_pc);
		next_record(handler_pc + 32'd4);
		next_record(handler_pc + 32'd8);
		@(posedge i_clock);
		i_irq_pending <= 1'b0;
		next_record(handler_pc + 32'd12);
		check_value("dispatch count", 32'(dispatch_count), 32'(count_before + 1));
	endtask

	task automatic irq_after_sequential();
		int count_before;
		logic [31:0] pc;
		bit dispatched;
		count_before = dispatch_count;
		drive_jump(32'h0000_0400);
		next_record(32'h0000_0400);
		next_record(32'h0000_0404);
		@(posedge i_clock);
		i_irq_pending <= 1'b1;
		pc = 32'h0000_0408;
		dispatched = 1'b0;
		for (int i = 0; i < 4 && !dispatched; i++) begin
			next_record(pc);
			if (o_irq_dispatched) begin
				dispatched = 1'b1;
				check_value("o_irq_epc", o_irq_epc, pc + 32'd4);
			end
			pc = pc + 32'd4;
		end
		if (!dispatched) begin
			fail_run("Interrupt edge during a sequential run was not dispatched");
		end else begin
			@(posedge i_clock);
			i_irq_pending <= 1'b0;
		end
		for (int i = 0; i < 4; i++) begin
			next_record(handler_pc + 32'(4 * i));
		end
		check_value("dispatch count", 32'(dispatch_count), 32'(count_before + 1));
	endtask

	task automatic back_pressure();
		logic [31:0] pc;
		logic [7:0] held_tag;
		logic [31:0] held_pc;
		logic [31:0] held_word;
		int hold_cycles;
		drive_jump(32'h0000_0500);
		pc = 32'h0000_0500;
		for (int round = 0; round < 3; round++) begin
			next_record(pc);
			pc = pc + 32'd4;
			hold_cycles = 3 + ($random(seed) & 7);
			@(posedge i_clock);
			i_busy <= 1'b1;
			// A hit can still be accepted on the edge that raises busy
			@(negedge i_clock);
			if (o_fetch_tag != last_tag) begin
				check_record(pc);
				pc = pc + 32'd4;
			end
			// The last delivered record must stay in place
			held_tag = last_tag;
			held_pc = pc - 32'd4;
			held_word = memory_i.mem[held_pc[11:2]];
			repeat (hold_cycles) begin
				@(negedge i_clock);
				check_value("o_fetch_tag", 32'(o_fetch_tag), 32'(held_tag));
				check_value("o_fetch_pc", o_fetch_pc, held_pc);
				check_value("o_fetch_instruction", o_fetch_instruction, held_word);
			end
			@(posedge i_clock);
			i_busy <= 1'b0;
		end
		while (pc <= 32'h0000_051C) begin
			next_record(pc);
			pc = pc + 32'd4;
		end
	endtask

	task automatic cache_reuse();
		int requests_before;
		drive_jump(32'h0000_0600);
		for (int i = 0; i < 5; i++) begin
			next_record(32'h0000_0600 + 32'(4 * i));
		end
		requests_before = request_count;
		drive_jump(32'h0000_0600);
		for (int i = 0; i < 5; i++) begin
			next_record(32'h0000_0600 + 32'(4 * i));
		end
		check_value("bus request count", 32'(request_count), 32'(requests_before));
	endtask

	initial begin
		i_reset = 1'b1;
		i_busy = 1'b0;
		i_jump = 1'b0;
		i_jump_pc = '0;
		i_irq_pending = 1'b0;
		i_irq_pc = handler_pc;
		seed = random_seed;
		error_count = 0;
		last_tag = '0;
		@(posedge i_clock);
		load_program();
		repeat (6) @(posedge i_clock);
		@(negedge i_clock);
		check_value("o_fetch_tag", 32'(o_fetch_tag), 32'd0);
		check_value("o_bus_request", 32'(o_bus_request), 32'd0);
		check_value("o_irq_dispatched", 32'(o_irq_dispatched), 32'd0);
		@(posedge i_clock);
		i_reset <= 1'b0;

		sequential_fetch();
		jump_hold();
		trap_wait();
		irq_after_sequential();
		back_pressure();
		cache_reuse();

		if (error_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
hw/isa_pkg.sv
hw/fetch_pkg.sv
hw/icache_line.sv
hw/icache_refill.sv
hw/icache.sv
hw/instr_classify.sv
hw/fetch_unit.sv
hw/fetch_top.sv
tb/tb_bus_memory.sv
tb/tb_fetch_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := tb_fetch_top
FILE_LIST := verilog.f
BUILD_DIR := obj_dir
LOG := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
